//--- common/cps_mem_defs.svh
// Memory fabric widths
`ifndef CPS_MEM_DEFS_SVH
`define CPS_MEM_DEFS_SVH

// Top two client address bits pick the bank
`define CPS_MEM_ADDR_W 24

// SDRAM bank word address
`define CPS_MEM_BA_W 22

`define CPS_MEM_DATA_W 16
`define CPS_MEM_TAG_W 4

// Fixed by the two decoded address bits
`define CPS_MEM_NBANK 4

`endif

//--- common/cps_mem_pkg.sv
// Memory fabric types
`default_nettype none

package cps_mem_pkg;

    // Bank port sequencer states
    typedef enum logic [1:0] {
        // Empty, accepting a request
        ST_IDLE,
        // rd high, waiting for ack
        ST_REQ,
        // Waiting for rdy
        ST_WAIT,
        // Response held for the merger
        ST_HOLD
    } bank_state_e;

endpackage

`default_nettype wire

//--- common/mem_req_if.sv
// Bank request channel
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

interface mem_req_if;

    logic                      valid;
    logic                      ready;
    // Bank word address, bank bits already stripped
    logic [`CPS_MEM_BA_W-1:0]  addr;
    logic [`CPS_MEM_TAG_W-1:0] tag;

    modport router (
        output valid,
        output addr,
        output tag,
        input  ready
    );

    modport port (
        input  valid,
        input  addr,
        input  tag,
        output ready
    );

endinterface

`default_nettype wire

//--- common/mem_rsp_if.sv
// Bank response channel
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

interface mem_rsp_if;

    logic                       valid;
    logic                       ready;
    logic [`CPS_MEM_DATA_W-1:0] data;
    // Tag of the request this data belongs to
    logic [`CPS_MEM_TAG_W-1:0]  tag;

    // Bank port side
    modport port (
        output valid,
        output data,
        output tag,
        input  ready
    );

    // Merger side
    modport merge (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/bank_router.sv
// Bank request router
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

module bank_router (
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic [`CPS_MEM_ADDR_W-1:0]  req_addr,
    input  logic [`CPS_MEM_TAG_W-1:0]   req_tag,

    mem_req_if.router                   bank_req [`CPS_MEM_NBANK]
);

    logic [`CPS_MEM_ADDR_W-`CPS_MEM_BA_W-1:0] bank_sel;
    logic [`CPS_MEM_NBANK-1:0]                bank_ready;

    // Top address bits select the bank
    assign bank_sel = req_addr[`CPS_MEM_ADDR_W-1:`CPS_MEM_BA_W];

    genvar g;
    generate
        for (g = 0; g < `CPS_MEM_NBANK; g++) begin : g_bank
            // Only the addressed bank sees valid
            assign bank_req[g].valid = req_valid && (bank_sel == 2'(g));
            assign bank_req[g].addr  = req_addr[`CPS_MEM_BA_W-1:0];
            assign bank_req[g].tag   = req_tag;
            assign bank_ready[g]     = bank_req[g].ready;
        end
    endgenerate

    // Client stalls while the addressed port is busy
    assign req_ready = bank_ready[bank_sel];

endmodule

`default_nettype wire

//--- bank/bank_port.sv
// SDRAM bank port sequencer
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

module bank_port (
    input  logic                        VB,
    input  logic                        rst_n,

    mem_req_if.port                     req,
    mem_rsp_if.port                     rsp,

    // SDRAM bank side
    output logic [`CPS_MEM_BA_W-1:0]    ba_addr,
    output logic                        ba_rd,
    input  logic                        ba_ack,
    input  logic                        ba_rdy,
    input  logic [`CPS_MEM_DATA_W-1:0]  ba_data
);

    cps_mem_pkg::bank_state_e   state;
    cps_mem_pkg::bank_state_e   state_nx;

    logic [`CPS_MEM_BA_W-1:0]   addr_q;
    logic [`CPS_MEM_TAG_W-1:0]  tag_q;
    logic [`CPS_MEM_DATA_W-1:0] data_q;
    logic                       accept;
    logic                       capture;

    // One request at a time per bank
    assign req.ready = (state == cps_mem_pkg::ST_IDLE);
    assign accept    = req.valid && req.ready;
    assign capture   = (state == cps_mem_pkg::ST_WAIT) && ba_rdy;

    always_comb begin
        state_nx = state;
        case (state)
            cps_mem_pkg::ST_IDLE: begin
                if (req.valid) begin
                    state_nx = cps_mem_pkg::ST_REQ;
                end
            end
            // ack may come in the very first rd cycle
            cps_mem_pkg::ST_REQ: begin
                if (ba_ack) begin
                    state_nx = cps_mem_pkg::ST_WAIT;
                end
            end
            cps_mem_pkg::ST_WAIT: begin
                if (ba_rdy) begin
                    state_nx = cps_mem_pkg::ST_HOLD;
                end
            end
            cps_mem_pkg::ST_HOLD: begin
                if (rsp.ready) begin
                    state_nx = cps_mem_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nx = cps_mem_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state <= cps_mem_pkg::ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    // Request and response payload
    always_ff @(posedge VB) begin
        if (accept) begin
            addr_q <= req.addr;
            tag_q  <= req.tag;
        end
        if (capture) begin
            data_q <= ba_data;
        end
    end

    // Address stays stable for the whole access
    assign ba_addr = addr_q;
    assign ba_rd   = (state == cps_mem_pkg::ST_REQ);

    assign rsp.valid = (state == cps_mem_pkg::ST_HOLD);
    assign rsp.data  = data_q;
    assign rsp.tag   = tag_q;

endmodule

`default_nettype wire

//--- rtl/rsp_merge.sv
// Round-robin response merger
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

module rsp_merge (
    input  logic                        VB,
    input  logic                        rst_n,

    mem_rsp_if.merge                    bank_rsp [`CPS_MEM_NBANK],

    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [`CPS_MEM_DATA_W-1:0]  rsp_data,
    output logic [`CPS_MEM_TAG_W-1:0]   rsp_tag
);

    localparam int PTR_W = $clog2(`CPS_MEM_NBANK);

    logic [`CPS_MEM_NBANK-1:0]  bank_valid;
    logic [`CPS_MEM_DATA_W-1:0] bank_data [`CPS_MEM_NBANK];
    logic [`CPS_MEM_TAG_W-1:0]  bank_tag  [`CPS_MEM_NBANK];

    logic [PTR_W-1:0]           ptr;
    logic [PTR_W-1:0]           grant_idx;
    logic                       grant_hit;
    logic                       load;
    logic                       take;

    // Output register free, or draining this cycle
    assign load = !rsp_valid || rsp_ready;
    assign take = load && grant_hit;

    // First valid bank at or after the pointer
    always_comb begin
        logic [PTR_W-1:0] idx;
        grant_hit = 1'b0;
        grant_idx = ptr;
        for (int i = `CPS_MEM_NBANK - 1; i >= 0; i--) begin
            idx = ptr + PTR_W'(i);
            if (bank_valid[idx]) begin
                grant_hit = 1'b1;
                grant_idx = idx;
            end
        end
    end

    genvar g;
    generate
        for (g = 0; g < `CPS_MEM_NBANK; g++) begin : g_bank
            assign bank_valid[g] = bank_rsp[g].valid;
            assign bank_data[g]  = bank_rsp[g].data;
            assign bank_tag[g]   = bank_rsp[g].tag;
            // Only the winner is released
            assign bank_rsp[g].ready = take && (grant_idx == PTR_W'(g));
        end
    endgenerate

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            ptr       <= '0;
        end else begin
            if (load) begin
                rsp_valid <= grant_hit;
            end
            // Next search starts after the winner
            if (take) begin
                ptr <= grant_idx + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge VB) begin
        if (take) begin
            rsp_data <= bank_data[grant_idx];
            rsp_tag  <= bank_tag[grant_idx];
        end
    end

endmodule

`default_nettype wire

//--- rtl/cps_mem_top.sv
// ROM/RAM request fabric top
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

module cps_mem_top (
    input  logic                                            VB,
    input  logic                                            rst_n,

    // Client requests
    input  logic                                            req_valid,
    output logic                                            req_ready,
    input  logic [`CPS_MEM_ADDR_W-1:0]                      req_addr,
    input  logic [`CPS_MEM_TAG_W-1:0]                       req_tag,

    // Tagged responses
    output logic                                            rsp_valid,
    input  logic                                            rsp_ready,
    output logic [`CPS_MEM_DATA_W-1:0]                      rsp_data,
    output logic [`CPS_MEM_TAG_W-1:0]                       rsp_tag,

    // SDRAM banks
    output logic [`CPS_MEM_NBANK-1:0][`CPS_MEM_BA_W-1:0]    ba_addr,
    output logic [`CPS_MEM_NBANK-1:0]                       ba_rd,
    input  logic [`CPS_MEM_NBANK-1:0]                       ba_ack,
    input  logic [`CPS_MEM_NBANK-1:0]                       ba_rdy,
    input  logic [`CPS_MEM_NBANK-1:0][`CPS_MEM_DATA_W-1:0]  ba_data
);

    mem_req_if req_if [`CPS_MEM_NBANK] ();
    mem_rsp_if rsp_if [`CPS_MEM_NBANK] ();

    bank_router u_router (
        .req_valid  ( req_valid ),
        .req_ready  ( req_ready ),
        .req_addr   ( req_addr  ),
        .req_tag    ( req_tag   ),
        .bank_req   ( req_if    )
    );

    genvar g;
    generate
        for (g = 0; g < `CPS_MEM_NBANK; g++) begin : g_bank
            bank_port u_port (
                .VB         ( VB            ),
                .rst_n      ( rst_n         ),
                .req        ( req_if[g]     ),
                .rsp        ( rsp_if[g]     ),
                .ba_addr    ( ba_addr[g]    ),
                .ba_rd      ( ba_rd[g]      ),
                .ba_ack     ( ba_ack[g]     ),
                .ba_rdy     ( ba_rdy[g]     ),
                .ba_data    ( ba_data[g]    )
            );
        end
    endgenerate

    rsp_merge u_merge (
        .VB         ( VB        ),
        .rst_n      ( rst_n     ),
        .bank_rsp   ( rsp_if    ),
        .rsp_valid  ( rsp_valid ),
        .rsp_ready  ( rsp_ready ),
        .rsp_data   ( rsp_data  ),
        .rsp_tag    ( rsp_tag   )
    );

endmodule

`default_nettype wire

//--- tests/cps_mem_sva.sv
// Fabric handshake assertions
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

module cps_mem_sva (
    input  logic                                    VB,
    input  logic                                    rst_n,
    input  logic                                    rsp_valid,
    input  logic                                    rsp_ready,
    input  logic [`CPS_MEM_DATA_W-1:0]              rsp_data,
    input  logic [`CPS_MEM_TAG_W-1:0]               rsp_tag,
    input  logic [`CPS_MEM_NBANK-1:0]               ba_rd,
    input  logic [`CPS_MEM_NBANK-1:0]               ba_ack
);

    // High from the second reset edge on
    logic in_reset_q;

    always @(posedge VB) begin
        in_reset_q <= !rst_n;
    end

    // Stalled response holds its payload
    a_rsp_hold: assert property (@(posedge VB) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_tag))
        else $error("Response changed while stalled");

    a_reset_quiet: assert property (@(posedge VB)
        in_reset_q && !rst_n |-> !rsp_valid && (ba_rd == '0))
        else $error("Outputs active during reset");

    genvar g;
    generate
        for (g = 0; g < `CPS_MEM_NBANK; g++) begin : g_bank
            // rd held up to the ack cycle
            a_rd_until_ack: assert property (@(posedge VB) disable iff (!rst_n)
                ba_rd[g] && !ba_ack[g] |=> ba_rd[g])
                else $error("Bank rd dropped before ack");
        end
    endgenerate

endmodule

bind cps_mem_top cps_mem_sva i_sva (
    .VB         ( VB        ),
    .rst_n      ( rst_n     ),
    .rsp_valid  ( rsp_valid ),
    .rsp_ready  ( rsp_ready ),
    .rsp_data   ( rsp_data  ),
    .rsp_tag    ( rsp_tag   ),
    .ba_rd      ( ba_rd     ),
    .ba_ack     ( ba_ack    )
);

`default_nettype wire

//--- tests/cps_mem_tb.sv
// Memory fabric testbench
`default_nettype none
`timescale 1ns/100ps

`include "cps_mem_defs.svh"

module cps_mem_tb;

    localparam int NUM_STIM = 16;
    localparam int TIMEOUT  = NUM_STIM * 40 + 100;

    logic                                           VB = 1'b0;
    logic                                           rst_n;
    logic                                           req_valid;
    logic                                           req_ready;
    logic [`CPS_MEM_ADDR_W-1:0]                     req_addr;
    logic [`CPS_MEM_TAG_W-1:0]                      req_tag;
    logic                                           rsp_valid;
    logic                                           rsp_ready;
    logic [`CPS_MEM_DATA_W-1:0]                     rsp_data;
    logic [`CPS_MEM_TAG_W-1:0]                      rsp_tag;
    logic [`CPS_MEM_NBANK-1:0][`CPS_MEM_BA_W-1:0]   ba_addr;
    logic [`CPS_MEM_NBANK-1:0]                      ba_rd;
    wire  [`CPS_MEM_NBANK-1:0]                      ba_ack;
    wire  [`CPS_MEM_NBANK-1:0]                      ba_rdy;
    wire  [`CPS_MEM_NBANK-1:0][`CPS_MEM_DATA_W-1:0] ba_data;

    // Address, tag, rsp_ready low cycles, drain flag
    logic [32:0]                stim [NUM_STIM];
    integer                     seed = 32'h576b;
    int                         error_cnt = 0;
    int                         cycle = 0;
    int                         issue_cnt = 0;
    int                         done_cnt = 0;

    // Scoreboard by tag, plus per-bank issue order
    logic [15:0]                pending = '0;
    logic [`CPS_MEM_DATA_W-1:0] exp_data    [16];
    logic [1:0]                 tag_bank    [16];
    logic [`CPS_MEM_TAG_W-1:0]  issue_order [`CPS_MEM_NBANK][16];
    int                         issued_bank [`CPS_MEM_NBANK];
    int                         done_bank   [`CPS_MEM_NBANK];
    int                         last_accept [`CPS_MEM_NBANK];

    logic                       stall_q = 1'b0;
    logic [`CPS_MEM_DATA_W-1:0] held_data;
    logic [`CPS_MEM_TAG_W-1:0]  held_tag;

    cps_mem_top i_dut (
        .VB         ( VB        ),
        .rst_n      ( rst_n     ),
        .req_valid  ( req_valid ),
        .req_ready  ( req_ready ),
        .req_addr   ( req_addr  ),
        .req_tag    ( req_tag   ),
        .rsp_valid  ( rsp_valid ),
        .rsp_ready  ( rsp_ready ),
        .rsp_data   ( rsp_data  ),
        .rsp_tag    ( rsp_tag   ),
        .ba_addr    ( ba_addr   ),
        .ba_rd      ( ba_rd     ),
        .ba_ack     ( ba_ack    ),
        .ba_rdy     ( ba_rdy    ),
        .ba_data    ( ba_data   )
    );

    always #50 VB = ~VB;

    // Word stored in each bank model
    function automatic logic [15:0] bank_word(input int bank, input logic [21:0] addr);
        return addr[15:0] ^ 16'hA5A5 ^ (16'(bank) * 16'h1111);
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            error_cnt++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // SDRAM bank models with random ack and rdy delays
    genvar g;
    generate
        for (g = 0; g < `CPS_MEM_NBANK; g++) begin : g_bank_model
            logic        ack_r  = 1'b0;
            logic        rdy_r  = 1'b0;
            logic [15:0] data_r = '0;
            int          phase  = 0;
            int          cnt    = 0;

            assign ba_ack[g]  = ack_r;
            assign ba_rdy[g]  = rdy_r;
            assign ba_data[g] = data_r;

            always @(negedge VB) begin
                ack_r = 1'b0;
                rdy_r = 1'b0;
                if (!rst_n) begin
                    phase = 0;
                end else begin
                    if (phase == 0 && ba_rd[g]) begin
                        cnt   = $random(seed) & 3;
                        phase = 1;
                    end
                    if (phase == 1) begin
                        assert (ba_rd[g]) else begin
                            error_cnt++;
                            $display("Bank %0d dropped rd before ack", g);
                        end
                        if (cnt == 0) begin
                            ack_r = 1'b1;
                            cnt   = ($random(seed) & 3) + 1;
                            phase = 2;
                        end else begin
                            cnt = cnt - 1;
                        end
                    end else if (phase == 2) begin
                        cnt = cnt - 1;
                        if (cnt == 0) begin
                            rdy_r  = 1'b1;
                            data_r = bank_word(g, ba_addr[g]);
                            phase  = 0;
                        end
                    end
                end
            end
        end
    endgenerate

    task automatic send_request(input logic [23:0] addr, input logic [3:0] tag);
        logic [1:0] bank;
        bank      = addr[23:22];
        req_valid = 1'b1;
        req_addr  = addr;
        req_tag   = tag;
        @(posedge VB);
        while (!req_ready) begin
            @(posedge VB);
        end
        // A port cannot finish a read in under three cycles
        assert (cycle - last_accept[bank] > 2) else begin
            error_cnt++;
            $display("Bank %0d accepted a request while its port was busy", bank);
        end
        last_accept[bank] = cycle;
        exp_data[tag]     = bank_word(bank, addr[21:0]);
        tag_bank[tag]     = bank;
        issue_order[bank][issued_bank[bank]] = tag;
        issued_bank[bank]++;
        pending[tag] = 1'b1;
        issue_cnt++;
        @(negedge VB);
    endtask

    task automatic check_response(input logic [3:0] tag, input logic [15:0] data);
        logic [1:0] bank;
        assert (pending[tag]) else begin
            error_cnt++;
            $display("Response with unknown or duplicate tag %h", tag);
        end
        if (pending[tag]) begin
            bank = tag_bank[tag];
            // Same bank returns in issue order
            check_value("rsp_tag", tag, issue_order[bank][done_bank[bank]]);
            check_value("rsp_data", data, exp_data[tag]);
            pending[tag] = 1'b0;
            done_bank[bank]++;
            done_cnt++;
        end
    endtask

    task automatic wait_all_done();
        while (done_cnt != issue_cnt) begin
            @(negedge VB);
        end
    endtask

    // Response monitor sampling flop outputs before they update
    always @(posedge VB) begin
        if (rst_n) begin
            if (stall_q) begin
                check_value("rsp_valid", rsp_valid, 1'b1);
                check_value("rsp_data", rsp_data, held_data);
                check_value("rsp_tag", rsp_tag, held_tag);
            end
            stall_q   = rsp_valid && !rsp_ready;
            held_data = rsp_data;
            held_tag  = rsp_tag;
            if (rsp_valid && rsp_ready) begin
                check_response(rsp_tag, rsp_data);
            end
        end
    end

    always @(posedge VB) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timeout after %0d cycles, %0d responses missing", cycle,
                     issue_cnt - done_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [23:0] addr;
        logic [3:0]  tag;
        logic [3:0]  hold;
        logic        drain;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_tag   = '0;
        rsp_ready = 1'b1;
        for (int b = 0; b < `CPS_MEM_NBANK; b++) begin
            issued_bank[b] = 0;
            done_bank[b]   = 0;
            last_accept[b] = -100;
        end

        // One read per bank with a drain after each
        stim[0]  = {24'h012345, 4'h0, 4'd0, 1'b1};
        stim[1]  = {24'h4ABCDE, 4'h1, 4'd0, 1'b1};
        stim[2]  = {24'h80F00F, 4'h2, 4'd2, 1'b1};
        stim[3]  = {24'hC13579, 4'h3, 4'd0, 1'b1};
        // All four banks back to back
        stim[4]  = {24'h000010, 4'h4, 4'd0, 1'b0};
        stim[5]  = {24'h400020, 4'h5, 4'd0, 1'b0};
        stim[6]  = {24'h800030, 4'h6, 4'd0, 1'b0};
        stim[7]  = {24'hC00040, 4'h7, 4'd0, 1'b1};
        // Same bank three times
        stim[8]  = {24'h800100, 4'h8, 4'd0, 1'b0};
        stim[9]  = {24'h800200, 4'h9, 4'd0, 1'b0};
        stim[10] = {24'h800300, 4'hA, 4'd0, 1'b1};
        // Back-pressure while reads are in flight
        stim[11] = {24'h4000AA, 4'hB, 4'd5, 1'b0};
        stim[12] = {24'hC000BB, 4'hC, 4'd0, 1'b0};
        stim[13] = {24'h0000CC, 4'hD, 4'd6, 1'b0};
        stim[14] = {24'h4000DD, 4'hE, 4'd0, 1'b0};
        stim[15] = {24'h8000EE, 4'hF, 4'd4, 1'b1};

        @(negedge VB);
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("ba_rd", ba_rd, 4'h0);
        @(negedge VB);
        rst_n = 1'b1;
        @(negedge VB);
        check_value("req_ready", req_ready, 1'b1);
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("ba_rd", ba_rd, 4'h0);

        for (int i = 0; i < NUM_STIM; i++) begin
            {addr, tag, hold, drain} = stim[i];
            send_request(addr, tag);
            req_valid = 1'b0;
            if (hold != 0) begin
                // Stall counted from the first waiting response
                rsp_ready = 1'b0;
                while (!rsp_valid) begin
                    @(negedge VB);
                end
                repeat (hold) @(negedge VB);
                rsp_ready = 1'b1;
            end
            if (drain) begin
                wait_all_done();
            end
        end

        wait_all_done();
        @(negedge VB);
        check_value("req_ready", req_ready, 1'b1);

        $display("Errors: %0d", error_cnt);
        if (error_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/cps_mem_pkg.sv
common/mem_req_if.sv
common/mem_rsp_if.sv
rtl/bank_router.sv
bank/bank_port.sv
rtl/rsp_merge.sv
rtl/cps_mem_top.sv
tests/cps_mem_sva.sv
tests/cps_mem_tb.sv
